// ==== common/chain_defs.svh ====
`ifndef CHAIN_DEFS_SVH
`define CHAIN_DEFS_SVH

// Width of one sample on every port of the chain
`define HB_WIDTH 18

// Width of the accumulator inside each decimator stage
// The product of two samples plus the shifted centre tap fits in it
`define HB_ACC_WIDTH 36

// Halfband taps in the form A 0 B 0.5 B 0 A
// The outer tap A sits at the first and the seventh position
`define HB_COEFF_A (-18'sd10690)

// The inner tap B sits at the third and the fifth position
`define HB_COEFF_B (18'sd75809)

// Final-stage outputs held back after each start of the chain
// These carry the filter transient and are never delivered downstream
`define HB_SETTLE_OUTPUTS 4

`endif

// ==== common/sample_pkg.sv ====
`default_nettype none

`include "chain_defs.svh"

// Data types shared by the decimator stages and the top level
package sample_pkg;

   // One signed sample as it travels between the stages
   typedef logic signed [`HB_WIDTH-1:0] sample_t;

   // Full product of a sample and an 18-bit tap
   typedef logic signed [2*`HB_WIDTH-1:0] prod_t;

   // Accumulator for the centre sample and the two tap products
   // The rounding stage brings it back to sample width
   typedef logic signed [`HB_ACC_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire

// ==== common/chain_ctrl_pkg.sv ====
`default_nettype none

// Control types for the chain sequencer
package chain_ctrl_pkg;

   // Sequencer states
   // IDLE holds the stages stopped
   // WARMUP runs the stages but suppresses their output
   // STREAM passes every final output downstream
   typedef enum logic [1:0]
   {
      IDLE   = 2'd0,
      WARMUP = 2'd1,
      STREAM = 2'd2
   } chain_state_t;

endpackage

`default_nettype wire

// ==== hb_dec/round_sd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chain_defs.svh"

// Sigma-delta rounding from accumulator width down to sample width
module round_sd
(
   input  wire                         clk,
   input  wire                         rst,
   input  wire sample_pkg::acc_t       in,
   input  wire                         strobe_in,
   output sample_pkg::sample_t         out,
   output logic                        strobe_out
);
   import sample_pkg::*;

   localparam int frac_w = `HB_ACC_WIDTH - `HB_WIDTH;

   logic [frac_w-1:0]               err;
   logic signed [`HB_ACC_WIDTH:0]   sum;
   logic                            ovf;
   sample_t                         out_next;

   // The fraction dropped last time is added back in before truncating
   // Over many samples the truncation error then averages to zero
   assign sum = $signed({in[`HB_ACC_WIDTH-1], in})
              + $signed({{(`HB_WIDTH + 1){1'b0}}, err});

   // The carried error is never negative, so only the top end can overflow
   assign ovf = sum[`HB_ACC_WIDTH] ^ sum[`HB_ACC_WIDTH-1];

   assign out_next = ovf ? {1'b0, {(`HB_WIDTH - 1){1'b1}}}
                         : sum[`HB_ACC_WIDTH-1:frac_w];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         err        <= '0;
         strobe_out <= 1'b0;
      end
      else
      begin
         strobe_out <= strobe_in;
         // A clipped sample drops its error instead of carrying it on
         if (strobe_in)
            err <= ovf ? '0 : sum[frac_w-1:0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (strobe_in)
         out <= out_next;
   end

endmodule

`default_nettype wire

// ==== hb_dec/small_hb_dec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chain_defs.svh"

// Short halfband decimate-by-two stage with impulse response A 0 B 0.5 B 0 A
module small_hb_dec
(
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         run,
   input  wire                         bypass,
   input  wire                         stb_in,
   input  wire sample_pkg::sample_t    data_in,
   output logic                        stb_out,
   output sample_pkg::sample_t         data_out
);
   import sample_pkg::*;

   localparam sample_t coeff_a = `HB_COEFF_A;
   localparam sample_t coeff_b = `HB_COEFF_B;

   logic                        stb_d1;
   sample_t                     data_d1;
   logic                        phase;
   logic                        go;
   logic [4:1]                  go_d;
   sample_t                     dly [1:6];
   logic signed [`HB_WIDTH:0]   pair_a_full;
   logic signed [`HB_WIDTH:0]   pair_b_full;
   sample_t                     sum_a;
   sample_t                     sum_b;
   sample_t                     middle;
   sample_t                     mult_sum;
   sample_t                     mult_coeff;
   prod_t                       prod;
   acc_t                        accum;
   sample_t                     rnd_data;
   logic                        rnd_stb;

   // Inputs are registered once before anything else looks at them
   always_ff @(posedge clk)
   begin
      if (rst)
         stb_d1 <= 1'b0;
      else
         stb_d1 <= stb_in;
   end

   always_ff @(posedge clk)
   begin
      data_d1 <= data_in;
   end

   // The phase flips on every registered sample
   // A computation starts on the second sample of each pair
   always_ff @(posedge clk)
   begin
      if (rst || !run)
         phase <= 1'b0;
      else if (stb_d1)
         phase <= ~phase;
   end

   assign go = stb_d1 & phase;

   // Go pipeline that steps through multiply, accumulate and round
   // go_d[1] and go_d[2] share the multiplier, go_d[4] feeds the rounding
   always_ff @(posedge clk)
   begin
      if (rst || !run)
         go_d <= '0;
      else
         go_d <= {go_d[3:1], go};
   end

   // Six older samples behind the registered input
   // Only a real reset clears them, so a restart keeps the history
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 1; i <= 6; i++)
            dly[i] <= '0;
      end
      else if (stb_d1)
      begin
         dly[1] <= data_d1;
         for (int i = 2; i <= 6; i++)
            dly[i] <= dly[i-1];
      end
   end

   // Symmetric taps are added before the multiply
   // The sum is one bit wider and then halved to keep sample width
   // The taps carry the matching factor of two
   assign pair_a_full = data_d1 + dly[6];
   assign pair_b_full = dly[2] + dly[4];

   always_ff @(posedge clk)
   begin
      if (go)
      begin
         sum_a  <= pair_a_full[`HB_WIDTH:1];
         sum_b  <= pair_b_full[`HB_WIDTH:1];
         middle <= dly[3];
      end
   end

   // Inner pair goes through the multiplier first, outer pair one cycle later
   assign mult_sum   = go_d[1] ? sum_b : sum_a;
   assign mult_coeff = go_d[1] ? coeff_b : coeff_a;

   always_ff @(posedge clk)
   begin
      if (go_d[1] || go_d[2])
         prod <= mult_coeff * mult_sum;
   end

   // The centre tap of one half is the sample shifted up by 16 bits
   always_ff @(posedge clk)
   begin
      if (go_d[2])
         accum <= (acc_t'(middle) <<< 16) + prod;
      else if (go_d[3])
         accum <= accum + prod;
   end

   round_sd u_round
   (
      .clk        (clk),
      .rst        (rst),
      .in         (accum),
      .strobe_in  (go_d[4]),
      .out        (rnd_data),
      .strobe_out (rnd_stb)
   );

   // Output register, which also carries the bypass path
   always_ff @(posedge clk)
   begin
      if (bypass ? stb_d1 : rnd_stb)
         data_out <= bypass ? data_d1 : rnd_data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         stb_out <= 1'b0;
      else if (bypass)
         stb_out <= stb_d1;
      else
         stb_out <= rnd_stb;
   end

endmodule

`default_nettype wire

// ==== source/settle_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chain_defs.svh"

// Counts final-stage strobes during warm-up and flags the end of it
module settle_counter
(
   input  wire    clk,
   input  wire    rst,
   input  wire    count_en,
   input  wire    count_clr,
   input  wire    stage_stb,
   output logic   settled
);
   // Room for the limit itself, and at least one bit when it is zero
   localparam int cnt_w = $clog2(`HB_SETTLE_OUTPUTS + 2);
   localparam logic [cnt_w-1:0] limit = cnt_w'(`HB_SETTLE_OUTPUTS);

   logic [cnt_w-1:0] cnt;
   logic [cnt_w-1:0] cnt_next;

   // The count stops at the limit and stays there until cleared
   always_comb
   begin
      cnt_next = cnt;
      if (count_en && stage_stb && (cnt != limit))
         cnt_next = cnt + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (rst || count_clr)
      begin
         cnt     <= '0;
         settled <= 1'b0;
      end
      else
      begin
         cnt     <= cnt_next;
         settled <= (cnt_next == limit);
      end
   end

endmodule

`default_nettype wire

// ==== source/chain_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chain_defs.svh"

// Start-up sequencer for the decimator chain
module chain_seq
(
   input  wire    clk,
   input  wire    rst,
   input  wire    run,
   input  wire    bypass,
   input  wire    stage_stb,
   input  wire    settled,
   output logic   stage_run,
   output logic   count_en,
   output logic   count_clr,
   output logic   stb_out,
   output logic   busy
);
   import chain_ctrl_pkg::*;

   // With nothing to discard the warm-up state is skipped
   localparam logic skip_warmup = (`HB_SETTLE_OUTPUTS == 0);

   chain_state_t state;
   chain_state_t state_next;

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= IDLE;
      else
         state <= state_next;
   end

   always_comb
   begin
      state_next = state;
      case (state)
         IDLE:
         begin
            if (run)
               state_next = (bypass || skip_warmup) ? STREAM : WARMUP;
         end
         WARMUP:
         begin
            if (!run)
               state_next = IDLE;
            else if (settled || bypass)
               state_next = STREAM;
         end
         STREAM:
         begin
            if (!run)
               state_next = IDLE;
         end
         default:
            state_next = IDLE;
      endcase
   end

   // The stages stop only in IDLE, and bypass keeps them moving
   assign stage_run = (state != IDLE) || bypass;

   // The counter is cleared as the chain starts and counts during warm-up
   assign count_clr = (state == IDLE) && run;
   assign count_en  = (state == WARMUP);

   // Final strobes leave only once the transient has passed
   assign stb_out = stage_stb && ((state == STREAM) || bypass);
   assign busy    = (state == WARMUP) && !bypass;

endmodule

`default_nettype wire

// ==== source/hb_dec_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decimate-by-four front end built from two halfband stages
module hb_dec_chain
(
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         run,
   input  wire                         bypass,
   input  wire                         stb_in,
   input  wire sample_pkg::sample_t    data_in,
   output logic                        stb_out,
   output sample_pkg::sample_t         data_out,
   output logic                        busy
);
   import sample_pkg::*;

   logic    s1_stb;
   sample_t s1_data;
   logic    s2_stb;
   logic    stage_run;
   logic    count_en;
   logic    count_clr;
   logic    settled;

   // First stage takes the input rate down by two
   small_hb_dec u_s1
   (
      .clk      (clk),
      .rst      (rst),
      .run      (stage_run),
      .bypass   (bypass),
      .stb_in   (stb_in),
      .data_in  (data_in),
      .stb_out  (s1_stb),
      .data_out (s1_data)
   );

   // Second stage halves the rate again, its data goes straight out
   small_hb_dec u_s2
   (
      .clk      (clk),
      .rst      (rst),
      .run      (stage_run),
      .bypass   (bypass),
      .stb_in   (s1_stb),
      .data_in  (s1_data),
      .stb_out  (s2_stb),
      .data_out (data_out)
   );

   // Sequencer gates the final strobe until the transient has passed
   chain_seq u_seq
   (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .bypass    (bypass),
      .stage_stb (s2_stb),
      .settled   (settled),
      .stage_run (stage_run),
      .count_en  (count_en),
      .count_clr (count_clr),
      .stb_out   (stb_out),
      .busy      (busy)
   );

   settle_counter u_cnt
   (
      .clk       (clk),
      .rst       (rst),
      .count_en  (count_en),
      .count_clr (count_clr),
      .stage_stb (s2_stb),
      .settled   (settled)
   );

endmodule

`default_nettype wire

// ==== tests/hb_dec_chain_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chain_defs.svh"

// Protocol checker bound into the top level of the decimator chain
module hb_dec_chain_chk
(
   input wire                            clk,
   input wire                            rst,
   input wire                            run,
   input wire                            bypass,
   input wire                            stb_in,
   input wire sample_pkg::sample_t       data_in,
   input wire                            stb_out,
   input wire sample_pkg::sample_t       data_out,
   input wire                            busy,
   input wire                            stage_stb,
   input wire chain_ctrl_pkg::chain_state_t state
);
   import sample_pkg::*;
   import chain_ctrl_pkg::*;

   int         fail_cnt;
   logic [1:0] in_cnt;
   logic       grp_end;
   int         sup_cnt;
   logic       run_seen;

   initial fail_cnt = 0;

   // Set once run has been seen after a reset
   always_ff @(posedge clk)
   begin
      if (rst)
         run_seen <= 1'b0;
      else if (run)
         run_seen <= 1'b1;
   end

   // Position of each input inside its group of four
   // The stages restart their phase whenever the chain is idle
   always_ff @(posedge clk)
   begin
      if (rst || (state == IDLE) || bypass)
         in_cnt <= '0;
      else if (stb_in)
         in_cnt <= in_cnt + 1'b1;
   end

   // The fourth input of a group is the one that completes an output
   assign grp_end = stb_in && !bypass && (state != IDLE) && (in_cnt == 2'd3);

   // Stage-2 strobes that fell into the warm-up window since the last start
   always_ff @(posedge clk)
   begin
      if (rst || (state == IDLE))
         sup_cnt <= 0;
      else if (stage_stb && (state == WARMUP))
         sup_cnt <= sup_cnt + 1;
   end

   a_reset_state: assert property (@(posedge clk) rst |=> (state == IDLE) && !busy && !stb_out)
   else
   begin
      fail_cnt++;
      $error("reset did not return the sequencer to idle with strobe and busy low");
   end

   // Nothing leaves the chain between reset and the first start
   a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
      !run_seen |-> !stb_out && !busy)
   else
   begin
      fail_cnt++;
      $error("output strobe or busy seen before the chain was first started");
   end

   // Every normal output must trace back to a completed group 14 cycles earlier
   a_latency: assert property (@(posedge clk) disable iff (rst)
      stb_out && !bypass |-> $past(grp_end, 14))
   else
   begin
      fail_cnt++;
      $error("output strobe without a completed group of four 14 cycles before");
   end

   a_ratio: assert property (@(posedge clk) disable iff (rst)
      grp_end ##14 ((state == STREAM) && !bypass) |-> stb_out)
   else
   begin
      fail_cnt++;
      $error("a completed group of four produced no output while streaming");
   end

   a_warmup_start: assert property (@(posedge clk) disable iff (rst)
      (state == IDLE) && run && !bypass |=> busy)
   else
   begin
      fail_cnt++;
      $error("busy did not rise when the chain was started");
   end

   // Warm-up may only end once exactly the settle count has been swallowed
   a_settle_count: assert property (@(posedge clk) disable iff (rst)
      $fell(busy) && run && !bypass |-> (sup_cnt == `HB_SETTLE_OUTPUTS))
   else
   begin
      fail_cnt++;
      $error("warm-up ended after a wrong number of suppressed outputs");
   end

   // A start in bypass goes straight to streaming without a warm-up
   a_bypass_skip: assert property (@(posedge clk) disable iff (rst)
      (state == IDLE) && run && bypass |=> (state == STREAM))
   else
   begin
      fail_cnt++;
      $error("a start in bypass did not skip the warm-up");
   end

   a_bypass_latency: assert property (@(posedge clk) disable iff (rst)
      bypass && stb_in |-> ##4 (stb_out && (data_out == $past(data_in, 4))))
   else
   begin
      fail_cnt++;
      $error("bypass sample did not reach the output unchanged 4 cycles later");
   end

   a_stop: assert property (@(posedge clk) disable iff (rst)
      (!run && !bypass) [*15] |-> !stb_out)
   else
   begin
      fail_cnt++;
      $error("output strobes kept coming more than 14 cycles after run fell");
   end

endmodule

bind hb_dec_chain hb_dec_chain_chk u_chk
(
   .clk       (clk),
   .rst       (rst),
   .run       (run),
   .bypass    (bypass),
   .stb_in    (stb_in),
   .data_in   (data_in),
   .stb_out   (stb_out),
   .data_out  (data_out),
   .busy      (busy),
   .stage_stb (s2_stb),
   .state     (u_seq.state)
);

`default_nettype wire

// ==== tests/tb_hb_dec_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chain_defs.svh"

// Testbench for the decimate-by-four chain with a bit-true model of both stages
module tb_hb_dec_chain;
   import sample_pkg::*;

   localparam longint coeff_a = `HB_COEFF_A;
   localparam longint coeff_b = `HB_COEFF_B;
   localparam int frac_w = `HB_ACC_WIDTH - `HB_WIDTH;
   localparam longint acc_max = (64'sd1 <<< (`HB_ACC_WIDTH - 1)) - 1;
   localparam longint out_max = (64'sd1 <<< (`HB_WIDTH - 1)) - 1;
   localparam longint frac_mask = (64'sd1 <<< frac_w) - 1;
   // Every sample takes at most 4 cycles, and each segment adds about 60 idle cycles
   localparam int n_samples = 222;
   localparam int stim_cycles = n_samples * 4 + 6 * 60 + 16;
   localparam int timeout_cycles = 4 * stim_cycles + 200;

   logic    clk;
   logic    rst;
   logic    run;
   logic    bypass;
   logic    stb_in;
   sample_t data_in;
   logic    stb_out;
   sample_t data_out;
   logic    busy;

   // Model of both stages, index 0 is the first stage
   longint  m_dly [0:1][1:6];
   logic    m_phase [0:1];
   longint  m_err [0:1];
   int      warm_cnt;
   sample_t exp_q [$];
   sample_t exp_val;
   logic    check_out;
   int      data_errs;
   int      seq_errs;
   int      chk_errs;
   int      cycle_cnt;

   initial clk = 1'b0;
   always #20 clk = ~clk;

   hb_dec_chain u_dut
   (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .bypass   (bypass),
      .stb_in   (stb_in),
      .data_in  (data_in),
      .stb_out  (stb_out),
      .data_out (data_out),
      .busy     (busy)
   );

   // One sample into one halfband stage, returns 1 when the stage emits an output
   function automatic logic stage_step(input int s, input longint v, output longint y);
      longint sum_a;
      longint sum_b;
      longint acc;
      longint tot;
      logic   fire;
      fire = m_phase[s];
      y = 0;
      if (fire)
      begin
         // Pair sums are halved, the taps carry the factor of two
         sum_a = (v + m_dly[s][6]) >>> 1;
         sum_b = (m_dly[s][2] + m_dly[s][4]) >>> 1;
         // Centre tap of one half at a tap scale of 2 to the 17
         acc = m_dly[s][3] * 65536 + coeff_b * sum_b + coeff_a * sum_a;
         tot = acc + m_err[s];
         if (tot > acc_max)
         begin
            y = out_max;
            m_err[s] = 0;
         end
         else
         begin
            y = tot >>> frac_w;
            m_err[s] = tot & frac_mask;
         end
      end
      for (int i = 6; i > 1; i--)
         m_dly[s][i] = m_dly[s][i-1];
      m_dly[s][1] = v;
      m_phase[s] = ~m_phase[s];
      return fire;
   endfunction

   // A start of run only restarts the phases and the warm-up count
   function automatic void model_start();
      m_phase[0] = 1'b0;
      m_phase[1] = 1'b0;
      warm_cnt = 0;
   endfunction

   function automatic void model_reset();
      for (int s = 0; s < 2; s++)
      begin
         for (int i = 1; i <= 6; i++)
            m_dly[s][i] = 0;
         m_err[s] = 0;
      end
      model_start();
   endfunction

   task automatic apply_reset();
      rst = 1'b1;
      repeat (8) @(negedge clk);
      rst = 1'b0;
   endtask

   // Drives one strobe and waits a random 2 to 4 cycles before the next
   task automatic send_sample(input sample_t v);
      int     gap;
      longint y1;
      longint y2;
      gap = 2 + ($urandom % 3);
      stb_in = 1'b1;
      data_in = v;
      if (check_out)
      begin
         if (bypass)
            exp_q.push_back(v);
         else if (stage_step(0, v, y1))
         begin
            if (stage_step(1, y1, y2))
            begin
               if (warm_cnt < `HB_SETTLE_OUTPUTS)
                  warm_cnt++;
               else
                  exp_q.push_back(sample_t'(y2));
            end
         end
      end
      @(negedge clk);
      stb_in = 1'b0;
      repeat (gap - 1) @(negedge clk);
   endtask

   task automatic send_random(input int n);
      for (int i = 0; i < n; i++)
         send_sample(sample_t'($urandom));
   endtask

   task automatic send_impulse(input int n, input int pos);
      for (int i = 0; i < n; i++)
         send_sample((i == pos) ? sample_t'(65536) : sample_t'(0));
   endtask

   task automatic start_run();
      model_start();
      run = 1'b1;
      repeat (3) @(negedge clk);
   endtask

   // Waits until every predicted output has arrived, then lets the pipeline empty
   task automatic wait_drain();
      while (exp_q.size() != 0)
         @(negedge clk);
      repeat (30) @(negedge clk);
      assert (!busy)
      else
      begin
         seq_errs++;
         $display("busy still high at %0t after the warm-up outputs had passed", $time);
      end
   endtask

   // Each delivered output is compared with the head of the model queue
   always @(negedge clk)
   begin
      if (!rst && check_out && stb_out)
      begin
         if (exp_q.size() == 0)
         begin
            seq_errs++;
            $display("output strobe at %0t when no sample was expected", $time);
         end
         else
         begin
            exp_val = exp_q.pop_front();
            assert (data_out == exp_val)
            else
            begin
               data_errs++;
               $display("error at %0t: data_out is %0d, expected %0d", $time, data_out, exp_val);
            end
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles)
      begin
         $display("timeout after %0d cycles, the expected outputs never all arrived", cycle_cnt);
         $display("Test failed");
         $finish;
      end
   end

   initial
   begin
      void'($urandom(56));
      rst = 1'b1;
      run = 1'b0;
      bypass = 1'b0;
      stb_in = 1'b0;
      data_in = '0;
      check_out = 1'b1;
      data_errs = 0;
      seq_errs = 0;
      chk_errs = 0;
      cycle_cnt = 0;
      model_reset();
      apply_reset();
      repeat (10) @(negedge clk);

      // Impulse well past the warm-up, then random data
      // 114 samples leave the second stage on an odd phase at the stop
      start_run();
      send_impulse(48, 24);
      send_random(66);
      wait_drain();
      run = 1'b0;
      repeat (20) @(negedge clk);

      // Second start keeps the history but begins on a fresh phase
      start_run();
      send_random(32);
      wait_drain();

      // Stop in the middle of a stream, then a reset brings the model back in line
      check_out = 1'b0;
      send_random(40);
      run = 1'b0;
      // Samples keep arriving after the stop, yet no output may follow them
      send_random(16);
      repeat (30) @(negedge clk);
      apply_reset();
      model_reset();
      check_out = 1'b1;

      // Bypass passes every sample and skips the warm-up
      bypass = 1'b1;
      start_run();
      send_random(20);
      wait_drain();
      run = 1'b0;
      repeat (10) @(negedge clk);
      bypass = 1'b0;
      repeat (20) @(negedge clk);

      chk_errs = u_dut.u_chk.fail_cnt;
      $display("errors: data %0d, sequence %0d, checker %0d", data_errs, seq_errs, chk_errs);
      if ((data_errs + seq_errs + chk_errs) == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/sample_pkg.sv
common/chain_ctrl_pkg.sv
hb_dec/round_sd.sv
hb_dec/small_hb_dec.sv
source/settle_counter.sv
source/chain_seq.sv
source/hb_dec_chain.sv
tests/hb_dec_chain_chk.sv
tests/tb_hb_dec_chain.sv

// ==== Bender.yml ====
package:
  name: hb_dec_chain

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sample_pkg.sv
      - common/chain_ctrl_pkg.sv
      - hb_dec/round_sd.sv
      - hb_dec/small_hb_dec.sv
      - source/settle_counter.sv
      - source/chain_seq.sv
      - source/hb_dec_chain.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/hb_dec_chain_chk.sv
      - tests/tb_hb_dec_chain.sv
